/* wb_bus_pkg.sv */
// ================================================
// wishbone widths and bus types for the cache bus master
// the master drives its bus side as one packed struct
// which the top level flattens onto the o_wb_ pins
// ================================================
package wb_bus_pkg;

    // ================================================
    // bus widths
    // ================================================
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int SEL_W      = 4;

    // number of address bits that select a byte inside one bus word
    localparam int BYTE_OFF_W = $clog2(SEL_W);

    typedef logic [ADDR_W-1:0]     wb_addr_t;
    typedef logic [DATA_W-1:0]     wb_data_t;
    typedef logic [SEL_W-1:0]      wb_sel_t;
    typedef logic [BYTE_OFF_W-1:0] wb_byte_off_t;

    // ================================================
    // master driven bus
    // ================================================
    // cyc and stb are kept as separate fields even though this master
    // raises and drops them together on every cycle it runs
    typedef struct packed {
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
        logic     we;
        logic     cyc;
        logic     stb;
    } wb_out_t;

endpackage

/* mem_req_pkg.sv */
// ================================================
// request side definitions for the cache bus master
// holds the port numbering and priority order, the uniform
// request record passed between decoder, latches and
// sequencer, and the rule that turns byte enables into
// the low address bits of a bus cycle
// ================================================
package mem_req_pkg;
    import wb_bus_pkg::*;

    // the three request sources
    localparam int N_PORTS = 3;
    localparam int PORT_W  = $clog2(N_PORTS);

    typedef logic [PORT_W-1:0] port_idx_t;

    // a lower index means a higher priority at the arbiter
    localparam port_idx_t PORT_DC_CACHED   = port_idx_t'(0);
    localparam port_idx_t PORT_DC_UNCACHED = port_idx_t'(1);
    localparam port_idx_t PORT_ICACHE      = port_idx_t'(2);

    // one request as seen by the latches and the sequencer
    // after the latch the strobe bit carries the pending flag instead
    typedef struct packed {
        logic         strobe;
        logic         qword;
        logic         write;
        wb_addr_t     addr;
        wb_data_t     data;
        wb_sel_t      be;
        wb_byte_off_t addr_lo;
    } port_req_t;

    // single byte enables point at their own lane
    // half word enables point at the lower lane of the pair
    // anything else is treated as a word access at offset zero
    function automatic wb_byte_off_t lane_to_addr_lo(input wb_sel_t be);
        wb_byte_off_t lo;
        case (be)
            4'b0001: lo = 2'd0;
            4'b0010: lo = 2'd1;
            4'b0100: lo = 2'd2;
            4'b1000: lo = 2'd3;
            4'b0011: lo = 2'd0;
            4'b1100: lo = 2'd2;
            default: lo = 2'd0;
        endcase
        return lo;
    endfunction

endpackage

/* port_decode.sv */
// ================================================
// turns the icache and dcache request pins into one
// uniform request per port and routes the per-port beat
// acks from the sequencer back to the ready outputs
// purely combinational
// ================================================
`timescale 1ns/1ps

module port_decode
    import wb_bus_pkg::*;
    import mem_req_pkg::*;
(
    // icache side
    input  logic                    i_icache_req,
    input  logic                    i_icache_qword,
    input  wb_addr_t                i_icache_address,

    // dcache side, the attributes are shared by both strobes
    input  logic                    i_dcache_cached_req,
    input  logic                    i_dcache_uncached_req,
    input  logic                    i_dcache_qword,
    input  logic                    i_dcache_write,
    input  wb_data_t                i_dcache_write_data,
    input  wb_sel_t                 i_dcache_byte_enable,
    input  wb_addr_t                i_dcache_address,

    // one bit per port from the sequencer
    input  logic [N_PORTS-1:0]      i_beat_ack,

    output port_req_t [N_PORTS-1:0] o_port_req,
    output logic                    o_icache_ready,
    output logic                    o_dcache_cached_ready,
    output logic                    o_dcache_uncached_ready
);

    // byte enables only matter for writes, reads fetch the whole word
    wb_sel_t   dcache_be;
    port_req_t dcache_base;

    assign dcache_be = i_dcache_write ? i_dcache_byte_enable : '1;

    always_comb
    begin
        // common dcache record, each port then adds its own strobe
        dcache_base.strobe  = 1'b0;
        dcache_base.qword   = i_dcache_qword;
        dcache_base.write   = i_dcache_write;
        dcache_base.addr    = i_dcache_address;
        dcache_base.data    = i_dcache_write_data;
        dcache_base.be      = dcache_be;
        dcache_base.addr_lo = lane_to_addr_lo(dcache_be);
    end

    always_comb
    begin
        o_port_req[PORT_DC_CACHED]        = dcache_base;
        o_port_req[PORT_DC_CACHED].strobe = i_dcache_cached_req;

        // uncached accesses never fill a line
        o_port_req[PORT_DC_UNCACHED]        = dcache_base;
        o_port_req[PORT_DC_UNCACHED].strobe = i_dcache_uncached_req;
        o_port_req[PORT_DC_UNCACHED].qword  = 1'b0;

        // instruction fetches are word aligned reads of all four lanes
        o_port_req[PORT_ICACHE].strobe  = i_icache_req;
        o_port_req[PORT_ICACHE].qword   = i_icache_qword;
        o_port_req[PORT_ICACHE].write   = 1'b0;
        o_port_req[PORT_ICACHE].addr    = {i_icache_address[ADDR_W-1:BYTE_OFF_W],
                                           {BYTE_OFF_W{1'b0}}};
        o_port_req[PORT_ICACHE].data    = '0;
        o_port_req[PORT_ICACHE].be      = '1;
        o_port_req[PORT_ICACHE].addr_lo = lane_to_addr_lo('1);
    end

    // a ready pulse goes out on every acked beat of the port's transfer
    assign o_dcache_cached_ready   = i_beat_ack[PORT_DC_CACHED];
    assign o_dcache_uncached_ready = i_beat_ack[PORT_DC_UNCACHED];
    assign o_icache_ready          = i_beat_ack[PORT_ICACHE];

endmodule

/* request_latch.sv */
// ================================================
// holds one strobed request until the sequencer has
// finished its last beat, so a source can fire a single
// cycle strobe and carry on while the bus is busy
// the strobe bit of the output is the pending flag
// ================================================
`timescale 1ns/1ps

module request_latch
    import mem_req_pkg::*;
(
    input  logic      i_clk,
    input  logic      quick_n_reset,

    // strobe plus attributes from the decoder
    input  port_req_t i_req,

    // high in the cycle the last beat of this port is acked
    input  logic      i_done,

    output port_req_t o_held
);

    // ================================================
    // pending flag
    // ================================================
    logic      pending_r;
    port_req_t held_r;

    // a new strobe wins over done so a source that strobes again
    // right on its final ready is not lost
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            pending_r <= 1'b0;
        end
        else if (i_req.strobe)
        begin
            pending_r <= 1'b1;
        end
        else if (i_done)
        begin
            pending_r <= 1'b0;
        end
    end

    // ================================================
    // request attributes
    // ================================================
    // captured only on a strobe and left alone for the whole transfer
    always_ff @(posedge i_clk)
    begin
        if (i_req.strobe)
        begin
            held_r <= i_req;
        end
    end

    always_comb
    begin
        o_held        = held_r;
        o_held.strobe = pending_r;
    end

endmodule

/* bus_sequencer.sv */
// ================================================
// picks the highest priority pending request and runs it
// on the wishbone bus as a single word cycle or as a
// wrapping line fill of BURST_BEATS words
// beat acks and done are decoded straight from i_wb_ack
// ================================================
`timescale 1ns/1ps

module bus_sequencer
    import wb_bus_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int BURST_BEATS = 4
)
(
    input  logic                    i_clk,
    input  logic                    quick_n_reset,

    // held requests from the latches, strobe is the pending flag
    input  port_req_t [N_PORTS-1:0] i_held,
    input  logic                    i_wb_ack,

    output wb_out_t                 o_wb,
    output logic [N_PORTS-1:0]      o_done,
    output logic [N_PORTS-1:0]      o_beat_ack
);

    // the word index inside a line sits just above the byte offset
    localparam int BEAT_W  = $clog2(BURST_BEATS);
    localparam int WORD_LO = BYTE_OFF_W;
    localparam int WORD_HI = BYTE_OFF_W + BEAT_W - 1;

    typedef logic [BEAT_W-1:0] beat_t;

    // BURST takes every beat of a line fill but the last one
    // LAST_ACK waits for the only beat of a single or the final beat of a fill
    typedef enum logic [1:0] {
        IDLE,
        BURST,
        LAST_ACK
    } seq_state_t;

    seq_state_t         state_r;
    beat_t              beat_cnt_r;
    port_idx_t          serv_idx_r;
    logic               active_r;
    logic               we_r;
    wb_addr_t           adr_r;
    wb_data_t           dat_r;
    wb_sel_t            sel_r;

    logic               grant_valid;
    port_idx_t          grant_idx;
    port_req_t          grant_req;
    beat_t              next_word;
    logic [N_PORTS-1:0] serv_onehot;

    // ================================================
    // fixed priority arbiter
    // ================================================
    // the lowest index that is pending wins
    always_comb
    begin
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < N_PORTS; i++)
        begin
            if (i_held[i].strobe && !grant_valid)
            begin
                grant_valid = 1'b1;
                grant_idx   = port_idx_t'(i);
            end
        end
    end

    assign grant_req = i_held[grant_idx];

    // next word of the line, the carry out is dropped so it wraps
    assign next_word = adr_r[WORD_HI:WORD_LO] + beat_t'(1);

    // ================================================
    // state machine
    // ================================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r    <= IDLE;
            beat_cnt_r <= '0;
            serv_idx_r <= '0;
            active_r   <= 1'b0;
            we_r       <= 1'b0;
        end
        else
        begin
            case (state_r)
                IDLE:
                begin
                    beat_cnt_r <= '0;
                    if (grant_valid)
                    begin
                        serv_idx_r <= grant_idx;
                        active_r   <= 1'b1;
                        we_r       <= grant_req.write;
                        // only reads are ever filled as a line
                        if (grant_req.qword && !grant_req.write)
                        begin
                            state_r <= BURST;
                        end
                        else
                        begin
                            state_r <= LAST_ACK;
                        end
                    end
                end

                BURST:
                begin
                    if (i_wb_ack)
                    begin
                        beat_cnt_r <= beat_cnt_r + beat_t'(1);
                        // one beat left after this ack
                        if (beat_cnt_r == beat_t'(BURST_BEATS - 2))
                        begin
                            state_r <= LAST_ACK;
                        end
                    end
                end

                LAST_ACK:
                begin
                    if (i_wb_ack)
                    begin
                        active_r <= 1'b0;
                        we_r     <= 1'b0;
                        state_r  <= IDLE;
                    end
                end

                default:
                begin
                    state_r <= IDLE;
                end
            endcase
        end
    end

    // ================================================
    // address, data and byte lanes
    // ================================================
    // loaded at the start of a cycle and held through any wait states
    always_ff @(posedge i_clk)
    begin
        if (state_r == IDLE && grant_valid)
        begin
            adr_r <= {grant_req.addr[ADDR_W-1:BYTE_OFF_W], grant_req.addr_lo};
            dat_r <= grant_req.data;
            sel_r <= grant_req.be;
        end
        else if (state_r == BURST && i_wb_ack)
        begin
            adr_r[WORD_HI:WORD_LO] <= next_word;
        end
    end

    always_comb
    begin
        for (int i = 0; i < N_PORTS; i++)
        begin
            serv_onehot[i] = (serv_idx_r == port_idx_t'(i));
        end
    end

    // every acked beat is reported, done only on the final one
    assign o_beat_ack = (active_r && i_wb_ack) ? serv_onehot : '0;
    assign o_done     = (state_r == LAST_ACK && i_wb_ack) ? serv_onehot : '0;

    assign o_wb = '{adr: adr_r,
                    dat: dat_r,
                    sel: sel_r,
                    we:  we_r,
                    cyc: active_r,
                    stb: active_r};

endmodule

/* wb_master_top.sv */
// ================================================
// top level of the cache to wishbone bus master
// the decoder feeds one request latch per port and the
// sequencer drains the latches onto the bus
// BURST_BEATS sets the line fill length in words
// ================================================
`timescale 1ns/1ps

module wb_master_top
    import wb_bus_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int BURST_BEATS = 4
)
(
    input  logic     i_clk,
    input  logic     quick_n_reset,

    // icache requests
    input  logic     i_icache_req,
    input  logic     i_icache_qword,
    input  wb_addr_t i_icache_address,
    output wb_data_t o_icache_read_data,
    output logic     o_icache_ready,

    // dcache requests
    input  logic     i_dcache_cached_req,
    input  logic     i_dcache_uncached_req,
    input  logic     i_dcache_qword,
    input  logic     i_dcache_write,
    input  wb_data_t i_dcache_write_data,
    input  wb_sel_t  i_dcache_byte_enable,
    input  wb_addr_t i_dcache_address,
    output wb_data_t o_dcache_read_data,
    output logic     o_dcache_cached_ready,
    output logic     o_dcache_uncached_ready,

    // wishbone bus
    output wb_addr_t o_wb_adr,
    output wb_sel_t  o_wb_sel,
    output logic     o_wb_we,
    output wb_data_t o_wb_dat,
    output logic     o_wb_cyc,
    output logic     o_wb_stb,
    input  wb_data_t i_wb_dat,
    input  logic     i_wb_ack
);

    port_req_t [N_PORTS-1:0] port_req;
    port_req_t [N_PORTS-1:0] held_req;
    logic [N_PORTS-1:0]      done;
    logic [N_PORTS-1:0]      beat_ack;
    wb_out_t                 wb_out;

    port_decode u_decode (
        .i_icache_req            (i_icache_req),
        .i_icache_qword          (i_icache_qword),
        .i_icache_address        (i_icache_address),
        .i_dcache_cached_req     (i_dcache_cached_req),
        .i_dcache_uncached_req   (i_dcache_uncached_req),
        .i_dcache_qword          (i_dcache_qword),
        .i_dcache_write          (i_dcache_write),
        .i_dcache_write_data     (i_dcache_write_data),
        .i_dcache_byte_enable    (i_dcache_byte_enable),
        .i_dcache_address        (i_dcache_address),
        .i_beat_ack              (beat_ack),
        .o_port_req              (port_req),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready)
    );

    // one latch per request source
    generate
        for (genvar p = 0; p < N_PORTS; p++)
        begin : g_latch
            request_latch u_latch (
                .i_clk         (i_clk),
                .quick_n_reset (quick_n_reset),
                .i_req         (port_req[p]),
                .i_done        (done[p]),
                .o_held        (held_req[p])
            );
        end
    endgenerate

    bus_sequencer #(
        .BURST_BEATS (BURST_BEATS)
    ) u_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_held        (held_req),
        .i_wb_ack      (i_wb_ack),
        .o_wb          (wb_out),
        .o_done        (done),
        .o_beat_ack    (beat_ack)
    );

    // ================================================
    // bus pins
    // ================================================
    assign o_wb_adr = wb_out.adr;
    assign o_wb_sel = wb_out.sel;
    assign o_wb_we  = wb_out.we;
    assign o_wb_dat = wb_out.dat;
    assign o_wb_cyc = wb_out.cyc;
    assign o_wb_stb = wb_out.stb;

    // read data is only valid while the matching ready is high
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

endmodule

/* tb_clock_gen.sv */
// ================================================
// testbench clock and reset source
// 10 ns clock, reset held low for RESET_CYCLES rising edges
// ================================================
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
)
(
    output logic o_clk,
    output logic quick_n_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // release lands 1 ns after an edge like all other stimulus
    initial
    begin
        quick_n_reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        quick_n_reset = 1'b1;
    end

endmodule

/* tb_wb_memory.sv */
// ================================================
// wishbone slave memory for the testbench
// acks each beat after 0 to 3 extra wait cycles drawn
// from a galois lfsr and applies sel on writes
// covers the low 1 KB of the address space
// ================================================
`timescale 1ns/1ps

module tb_wb_memory
    import wb_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     quick_n_reset,
    input  wb_addr_t i_adr,
    input  wb_sel_t  i_sel,
    input  logic     i_we,
    input  wb_data_t i_dat,
    input  logic     i_cyc,
    input  logic     i_stb,
    output wb_data_t o_dat,
    output logic     o_ack
);

    localparam int MEM_WORDS = 256;

    wb_data_t    mem [MEM_WORDS];
    logic [31:0] lfsr_state = 32'h692290c4;
    logic [1:0]  wait_cnt;
    logic [1:0]  delay;
    logic [7:0]  idx;

    assign idx = i_adr[9:2];

    // every word starts with a value built from its own word address
    initial
    begin
        for (int w = 0; w < MEM_WORDS; w++)
        begin
            mem[w] = (w * 32'h01000193) ^ 32'h5a3c_0000 ^ w;
        end
    end

    // one lfsr step for each bit of the delay
    task automatic draw_delay(output logic [1:0] d);
        for (int b = 0; b < 2; b++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000)
                                       : (lfsr_state >> 1);
            d[b] = lfsr_state[0];
        end
    endtask

    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_ack    <= 1'b0;
            wait_cnt <= 2'd0;
        end
        else if (o_ack)
        begin
            // ack is a single cycle, then the next beat gets a fresh delay
            o_ack <= 1'b0;
            draw_delay(delay);
            wait_cnt <= delay;
        end
        else if (i_cyc && i_stb)
        begin
            if (wait_cnt == 2'd0)
            begin
                o_ack <= 1'b1;
                o_dat <= mem[idx];
                if (i_we)
                begin
                    for (int b = 0; b < SEL_W; b++)
                    begin
                        if (i_sel[b])
                        begin
                            mem[idx][8*b +: 8] <= i_dat[8*b +: 8];
                        end
                    end
                end
            end
            else
            begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* tb_wb_master.sv */
// ================================================
// testbench for the cache to wishbone bus master
// random single reads, line fills, writes and priority
// pairs are checked against a reference memory by
// assertions on every ready pulse and on the bus
// ================================================
`timescale 1ns/1ps

module tb_wb_master
    import wb_bus_pkg::*;
    import mem_req_pkg::*;
;

    localparam int BURST_BEATS = 4;
    localparam int BEAT_W      = $clog2(BURST_BEATS);
    localparam int N_TESTS     = 80;
    localparam int WATCHDOG    = N_TESTS * 40;

    // one expected transfer in the order the bus should serve it
    typedef struct packed {
        port_idx_t port;
        logic      fill;
        logic      write;
        wb_addr_t  addr;
        wb_data_t  data;
        wb_sel_t   be;
    } exp_txn_t;

    logic i_clk, quick_n_reset;
    logic i_icache_req, i_icache_qword;
    logic i_dcache_cached_req, i_dcache_uncached_req, i_dcache_qword, i_dcache_write;
    wb_addr_t i_icache_address, i_dcache_address, o_wb_adr;
    wb_data_t i_dcache_write_data, o_icache_read_data, o_dcache_read_data;
    wb_data_t o_wb_dat, i_wb_dat;
    wb_sel_t  i_dcache_byte_enable, o_wb_sel;
    logic o_icache_ready, o_dcache_cached_ready, o_dcache_uncached_ready;
    logic o_wb_we, o_wb_cyc, o_wb_stb, i_wb_ack;
    logic [N_PORTS-1:0] ready_vec;

    exp_txn_t    exp_q[$];
    wb_data_t    ref_mem [256];
    int          beat_k   = 0;
    int          done_cnt = 0;
    int          err_cnt  = 0;
    logic        in_reset_d = 1'b0;
    logic [31:0] lfsr_state = 32'h692290c4;

    tb_clock_gen #(.RESET_CYCLES(16)) u_clk (.o_clk(i_clk), .quick_n_reset(quick_n_reset));

    wb_master_top #(.BURST_BEATS(BURST_BEATS)) DUT (.*);

    tb_wb_memory u_mem (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_adr(o_wb_adr),
        .i_sel(o_wb_sel), .i_we(o_wb_we), .i_dat(o_wb_dat), .i_cyc(o_wb_cyc),
        .i_stb(o_wb_stb), .o_dat(i_wb_dat), .o_ack(i_wb_ack)
    );

    assign ready_vec = {o_icache_ready, o_dcache_uncached_ready, o_dcache_cached_ready};

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("Mismatch at %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000)
                                       : (lfsr_state >> 1);
            v[i] = lfsr_state[0];
        end
    endtask

    // single lanes and aligned halves point at their lowest lane
    function automatic logic [1:0] expected_lane(input wb_sel_t be);
        if (be == 4'b0010) return 2'd1;
        if (be == 4'b0100 || be == 4'b1100) return 2'd2;
        if (be == 4'b1000) return 2'd3;
        return 2'd0;
    endfunction

    // fills wrap inside the aligned line starting at the requested word
    function automatic wb_addr_t beat_address(input exp_txn_t t, input int k);
        logic [29:0] word;
        word = t.addr[31:2];
        if (t.write) return {word, expected_lane(t.be)};
        if (t.fill) word[BEAT_W-1:0] = word[BEAT_W-1:0] + BEAT_W'(k);
        return {word, 2'b00};
    endfunction

    function automatic wb_data_t merge_bytes(input wb_data_t old, input wb_data_t nw,
                                             input wb_sel_t be);
        for (int b = 0; b < 4; b++)
        begin
            if (be[b]) old[8*b +: 8] = nw[8*b +: 8];
        end
        return old;
    endfunction

    // ================================================
    // bus and reset assertions
    // ================================================
    always @(posedge i_clk) in_reset_d <= !quick_n_reset;

    assert property (@(posedge i_clk) in_reset_d |->
                     !o_wb_cyc && !o_wb_stb && !o_wb_we && ready_vec == '0)
        else report_mismatch("bus or ready active during reset");

    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
                     (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr) && $stable(o_wb_sel)
                     && $stable(o_wb_we) && $stable(o_wb_dat))
        else report_mismatch("bus changed while waiting for ack");

    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
                     !i_wb_ack |-> ready_vec == '0)
        else report_mismatch("ready pulse without ack");

    // each ready pulse must belong to the head transfer and carry its beat
    always @(posedge i_clk)
    begin
        exp_txn_t  cur;
        wb_addr_t  adr;
        wb_data_t  rdata;
        if (quick_n_reset && ready_vec != '0)
        begin
            if (exp_q.size() == 0)
            begin
                report_mismatch("ready pulse with no request outstanding");
            end
            cur   = exp_q[0];
            adr   = beat_address(cur, beat_k);
            rdata = (cur.port == PORT_ICACHE) ? o_icache_read_data : o_dcache_read_data;
            assert (ready_vec == (N_PORTS'(1) << cur.port))
                else report_mismatch($sformatf("ready %b for port %0d", ready_vec, cur.port));
            assert (o_wb_adr == adr)
                else report_mismatch($sformatf("adr %h expected %h", o_wb_adr, adr));
            if (cur.write)
            begin
                assert (o_wb_we && o_wb_sel == cur.be && o_wb_dat == cur.data)
                    else report_mismatch($sformatf("write we %b sel %b dat %h",
                                                   o_wb_we, o_wb_sel, o_wb_dat));
                ref_mem[adr[9:2]] = merge_bytes(ref_mem[adr[9:2]], cur.data, cur.be);
            end
            else
            begin
                assert (!o_wb_we && rdata == ref_mem[adr[9:2]])
                    else report_mismatch($sformatf("read %h expected %h at %h",
                                                   rdata, ref_mem[adr[9:2]], adr));
            end
            beat_k++;
            if (beat_k == (cur.fill ? BURST_BEATS : 1))
            begin
                void'(exp_q.pop_front());
                beat_k = 0;
                done_cnt++;
            end
        end
    end

    // ================================================
    // stimulus
    // ================================================
    task automatic send_icache(input logic qword, input wb_addr_t addr);
        i_icache_req     = 1'b1;
        i_icache_qword   = qword;
        i_icache_address = addr;
        exp_q.push_back('{PORT_ICACHE, qword, 1'b0, addr, 32'h0, 4'hf});
    endtask

    task automatic send_dcache(input logic cached, input logic qword, input logic write,
                               input wb_addr_t addr, input wb_data_t data, input wb_sel_t be);
        i_dcache_cached_req   = cached;
        i_dcache_uncached_req = !cached;
        i_dcache_qword        = qword;
        i_dcache_write        = write;
        i_dcache_address      = addr;
        i_dcache_write_data   = data;
        i_dcache_byte_enable  = be;
        exp_q.push_back('{cached ? PORT_DC_CACHED : PORT_DC_UNCACHED,
                          cached && qword && !write, write, addr, data,
                          write ? be : 4'hf});
    endtask

    task automatic end_strobes_and_wait(input int target);
        @(posedge i_clk);
        #1;
        i_icache_req          = 1'b0;
        i_dcache_cached_req   = 1'b0;
        i_dcache_uncached_req = 1'b0;
        while (done_cnt < target)
        begin
            @(posedge i_clk);
            #1;
        end
    endtask

    initial
    begin
        int target;
        logic [31:0] kind, adr, dat, be, flag;
        for (int w = 0; w < 256; w++)
        begin
            ref_mem[w] = (w * 32'h01000193) ^ 32'h5a3c_0000 ^ w;
        end
        {i_icache_req, i_icache_qword, i_dcache_cached_req} = '0;
        {i_dcache_uncached_req, i_dcache_qword, i_dcache_write} = '0;
        i_icache_address     = '0;
        i_dcache_address     = '0;
        i_dcache_write_data  = '0;
        i_dcache_byte_enable = '0;
        target = 0;
        wait (quick_n_reset);
        @(posedge i_clk);
        #1;
        for (int t = 0; t < N_TESTS; t++)
        begin
            rand_bits(3, kind);
            rand_bits(10, adr);
            rand_bits(32, dat);
            rand_bits(4, be);
            rand_bits(1, flag);
            if (be[3:0] == 4'h0) be = 32'hf;
            case (kind % 6)
                0: send_icache(1'b0, adr);
                1: send_icache(1'b1, adr);
                2: send_dcache(1'b1, flag[0], 1'b0, adr, dat, be[3:0]);
                3: send_dcache(1'b0, flag[0], 1'b0, adr, dat, be[3:0]);
                4:
                begin
                    send_dcache(flag[0], 1'b0, 1'b1, adr, dat, be[3:0]);
                    target++;
                    end_strobes_and_wait(target);
                    // the written word is read back so the merged bytes are seen
                    send_dcache(1'b0, 1'b0, 1'b0, adr, dat, 4'hf);
                end
                default:
                begin
                    // both strobes in one cycle, the dcache goes first
                    send_dcache(1'b1, 1'b1, 1'b0, adr, dat, 4'hf);
                    send_icache(flag[0], {22'h0, adr[9:0] ^ 10'h2a4});
                    target++;
                end
            endcase
            target++;
            end_strobes_and_wait(target);
        end
        if (err_cnt == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG + 16) @(posedge i_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sources.f */
wb_bus_pkg.sv
mem_req_pkg.sv
port_decode.sv
request_latch.sv
bus_sequencer.sv
wb_master_top.sv
tb_clock_gen.sv
tb_wb_memory.sv
tb_wb_master.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_wb_master
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
